/* rel_rr_arbiter.f */
+incdir+source
source/rel_arb_pkg.sv
source/arb_lock_state.sv
source/rr_priority_state.sv
source/rr_arb_tree.sv
source/tmr_decision_voter.sv
source/rel_rr_arbiter.sv
verification/tb_clock_gen.sv
verification/tb_rel_rr_arbiter.sv

/* run_sim.sh */
#!/bin/sh
# builds the arbiter testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_rel_rr_arbiter \
       -f rel_rr_arbiter.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Testbench passed$" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

/* verification/tb_rel_rr_arbiter.sv */
// testbench of the triple-redundant round-robin arbiter
// random requesters, back-pressure and flushes, a reference model of
// the lock and priority state, compare tasks and timed waits

`timescale 1ns/1ns
`include "rel_arb_config.svh"

module tb_rel_rr_arbiter;

  localparam int NumIn       = `ARB_NUM_IN;
  localparam int NumCycles   = 4000;
  localparam int MaxWait     = 8;
  localparam int WaitTimeout = 64;

  logic                                     clk;
  logic                                     rst_n;
  logic                                     flush;
  rel_arb_pkg::arb_req_vec_t                req;
  rel_arb_pkg::arb_data_t [`ARB_NUM_IN-1:0] data;
  logic                                     gnt_in;
  rel_arb_pkg::arb_req_vec_t                gnt_out;
  logic                                     req_out;
  rel_arb_pkg::arb_data_t                   data_out;
  rel_arb_pkg::arb_idx_t                    idx_out;
  logic                                     fault;

  // reference model state and the expectations of the current cycle
  rel_arb_pkg::arb_idx_t     m_rr;
  rel_arb_pkg::lock_state_e  m_lock;
  rel_arb_pkg::arb_req_vec_t m_held;
  rel_arb_pkg::arb_req_vec_t exp_eff;
  rel_arb_pkg::arb_idx_t     exp_idx;
  rel_arb_pkg::arb_idx_t     prev_idx;
  rel_arb_pkg::arb_data_t    prev_data;
  rel_arb_pkg::arb_req_vec_t seen_gnt;
  logic                      force_all;
  int                        wait_cnt [NumIn];
  int                        n_transfers;
  int                        n_flushes;
  int                        n_locked_new;
  integer                    seed;

  tb_clock_gen clock0 (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  rel_rr_arbiter dut0 (
    .clk_i   ( clk      ),
    .rst_ni  ( rst_n    ),
    .flush_i ( flush    ),
    .req_i   ( req      ),
    .data_i  ( data     ),
    .gnt_i   ( gnt_in   ),
    .gnt_o   ( gnt_out  ),
    .req_o   ( req_out  ),
    .data_o  ( data_out ),
    .idx_o   ( idx_out  ),
    .fault_o ( fault    )
  );

  //////////////////////////////////////////////////////////////////////
  // failure reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      abort_run($sformatf("Error: %s = 0x%h, expected 0x%h at %0t", name, act, exp, $time));
    end
  endtask

  task automatic check_idx(input string name, input rel_arb_pkg::arb_idx_t act,
                           input rel_arb_pkg::arb_idx_t exp);
    if (act !== exp) begin
      abort_run($sformatf("Error: %s = 0x%h, expected 0x%h at %0t", name, act, exp, $time));
    end
  endtask

  task automatic check_data(input string name, input rel_arb_pkg::arb_data_t act,
                            input rel_arb_pkg::arb_data_t exp);
    if (act !== exp) begin
      abort_run($sformatf("Error: %s = 0x%h, expected 0x%h at %0t", name, act, exp, $time));
    end
  endtask

  task automatic check_vec(input string name, input rel_arb_pkg::arb_req_vec_t act,
                           input rel_arb_pkg::arb_req_vec_t exp);
    if (act !== exp) begin
      abort_run($sformatf("Error: %s = 0x%h, expected 0x%h at %0t", name, act, exp, $time));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // settle one index bit per level, most significant first
  function automatic rel_arb_pkg::arb_idx_t pick_index(input rel_arb_pkg::arb_req_vec_t vec,
                                                       input rel_arb_pkg::arb_idx_t rr);
    rel_arb_pkg::arb_idx_t idx;
    int   base;
    int   half;
    logic lower_req;
    logic upper_req;
    idx  = '0;
    base = 0;
    for (int b = `ARB_IDX_WIDTH - 1; b >= 0; b--) begin
      half      = 1 << b;
      lower_req = 1'b0;
      upper_req = 1'b0;
      for (int i = 0; i < half; i++) begin
        lower_req |= vec[base + i];
        upper_req |= vec[base + half + i];
      end
      // upper wins with its priority bit set, else any lower request, else upper
      idx[b] = (upper_req && rr[b]) || !lower_req;
      if (idx[b]) begin
        base += half;
      end
    end
    return idx;
  endfunction

  // walking upward from rr+1 with wrap-around finds the first requester
  // above the priority, and otherwise the lowest one at or below it
  function automatic rel_arb_pkg::arb_idx_t next_priority(input rel_arb_pkg::arb_req_vec_t vec,
                                                          input rel_arb_pkg::arb_idx_t rr);
    rel_arb_pkg::arb_idx_t nxt;
    logic done;
    int   idx;
    nxt  = rr;
    done = 1'b0;
    for (int d = 1; d <= NumIn; d++) begin
      idx = (int'(rr) + d) % NumIn;
      if (!done && vec[idx]) begin
        nxt  = rel_arb_pkg::arb_idx_t'(idx);
        done = 1'b1;
      end
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // one clock cycle: drive, check, advance the model
  //////////////////////////////////////////////////////////////////////

  task automatic drive_inputs(input logic new_reqs, input logic drain);
    // requesters granted at the last edge are done
    req = req & ~seen_gnt;
    for (int k = 0; k < NumIn; k++) begin
      if (!req[k]) begin
        data[k] = rel_arb_pkg::arb_data_t'($random(seed));
        if (force_all || (new_reqs && (($random(seed) & 1) != 0))) begin
          req[k] = 1'b1;
        end
      end
    end
    gnt_in = drain || (($random(seed) & 3) != 0);
    flush  = !drain && !force_all && (($random(seed) & 63) == 0);
  endtask

  task automatic check_outputs();
    rel_arb_pkg::arb_req_vec_t exp_gnt;
    exp_eff = (m_lock == rel_arb_pkg::LOCK_HELD) ? m_held : req;
    exp_idx = pick_index(exp_eff, m_rr);
    exp_gnt = '0;
    check_bit("req_o", req_out, |exp_eff);
    check_bit("fault_o", fault, 1'b0);
    if (exp_eff != '0) begin
      check_idx("idx_o", idx_out, exp_idx);
      check_data("data_o", data_out, data[exp_idx]);
      if (gnt_in) begin
        exp_gnt[exp_idx] = 1'b1;
      end
      // a locked decision keeps index and payload whatever else arrives
      if (m_lock == rel_arb_pkg::LOCK_HELD) begin
        check_idx("idx_o while locked", idx_out, prev_idx);
        check_data("data_o while locked", data_out, prev_data);
        if ((req & ~m_held) != '0) begin
          n_locked_new++;
        end
      end
      if (force_all) begin
        check_idx("idx_o after reset or flush", idx_out, '0);
      end
    end
    check_vec("gnt_o", gnt_out, exp_gnt);
    prev_idx  = exp_idx;
    prev_data = data[exp_idx];
    seen_gnt  = gnt_out;
  endtask

  task automatic update_model();
    force_all = 1'b0;
    if (flush) begin
      m_rr      = '0;
      m_lock    = rel_arb_pkg::LOCK_OPEN;
      m_held    = '0;
      force_all = 1'b1;
      n_flushes++;
      // a flush starts a new round, so the waits start over
      foreach (wait_cnt[k]) begin
        wait_cnt[k] = 0;
      end
    end else begin
      if (exp_eff != '0 && gnt_in) begin
        n_transfers++;
        for (int k = 0; k < NumIn; k++) begin
          if (k == int'(exp_idx)) begin
            wait_cnt[k] = 0;
          end else if (req[k]) begin
            wait_cnt[k]++;
            if (wait_cnt[k] > MaxWait) begin
              abort_run($sformatf("requester %0d waited more than %0d transfers", k, MaxWait));
            end
          end
        end
        m_rr = next_priority(exp_eff, m_rr);
      end
      if (m_lock == rel_arb_pkg::LOCK_OPEN) begin
        m_held = req;
      end
      m_lock = (exp_eff != '0 && !gnt_in) ? rel_arb_pkg::LOCK_HELD : rel_arb_pkg::LOCK_OPEN;
    end
  endtask

  // outputs are checked 1 ns ahead of the rising edge
  task automatic run_cycle(input logic new_reqs, input logic drain);
    @(negedge clk);
    drive_inputs(new_reqs, drain);
    #1;
    check_outputs();
    @(posedge clk);
    update_model();
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : p_main
    int cycles;
    seed         = 63648;
    flush        = 1'b0;
    req          = '0;
    data         = '0;
    gnt_in       = 1'b0;
    m_rr         = '0;
    m_lock       = rel_arb_pkg::LOCK_OPEN;
    m_held       = '0;
    prev_idx     = '0;
    prev_data    = '0;
    seen_gnt     = '0;
    force_all    = 1'b1;
    n_transfers  = 0;
    n_flushes    = 0;
    n_locked_new = 0;
    foreach (wait_cnt[k]) begin
      wait_cnt[k] = 0;
    end
    cycles = 0;
    while (!rst_n && cycles < WaitTimeout) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      abort_run("reset was not released within the timeout");
    end
    // the first cycle has all eight requesting against priority 0
    repeat (NumCycles) begin
      run_cycle(1'b1, 1'b0);
    end
    // no new requests and the output always ready, so everything drains
    cycles = 0;
    while ((req & ~seen_gnt) != '0 && cycles < WaitTimeout) begin
      run_cycle(1'b0, 1'b1);
      cycles++;
    end
    if ((req & ~seen_gnt) != '0) begin
      abort_run("pending requests were not served within the drain timeout");
    end
    if (n_flushes == 0 || n_locked_new == 0) begin
      abort_run("the run never hit a flush or a locked cycle with new requests");
    end else begin
      $display("transfers %0d, flushes %0d, locked cycles with new requests %0d",
               n_transfers, n_flushes, n_locked_new);
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

/* verification/tb_clock_gen.sv */
// clock and reset source of the arbiter testbench
// 4 ns clock, reset held low for the first five cycles

`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HalfPeriod  = 2;
  localparam int ResetCycles = 5;

  initial begin : p_clock
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  initial begin : p_reset
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    // release between edges so no flop sees reset and clock together
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* source/rel_rr_arbiter.sv */
// top level of the triple-redundant round-robin arbiter
// lock state, priority state, three arbitration tree copies and the
// decision voter, wired into one req/gnt arbiter for eight requesters

`timescale 1ns/1ns
`include "rel_arb_config.svh"

module rel_rr_arbiter (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     flush_i,
  input  rel_arb_pkg::arb_req_vec_t                req_i,
  input  rel_arb_pkg::arb_data_t [`ARB_NUM_IN-1:0] data_i,
  input  logic                                     gnt_i,
  output rel_arb_pkg::arb_req_vec_t                gnt_o,
  output logic                                     req_o,
  output rel_arb_pkg::arb_data_t                   data_o,
  output rel_arb_pkg::arb_idx_t                    idx_o,
  output logic                                     fault_o
);

  // requests as the trees see them, frozen while the lock holds
  rel_arb_pkg::arb_req_vec_t eff_req;
  // current round-robin priority
  rel_arb_pkg::arb_idx_t     rr;

  // per-copy decisions on their way to the voter
  rel_arb_pkg::arb_req_vec_t [`ARB_NUM_COPIES-1:0] tree_gnt;
  logic [`ARB_NUM_COPIES-1:0]                      tree_req;
  rel_arb_pkg::arb_idx_t [`ARB_NUM_COPIES-1:0]     tree_idx;
  rel_arb_pkg::arb_data_t [`ARB_NUM_COPIES-1:0]    tree_data;

  //////////////////////////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////////////////////////

  // the voted req_o feeds back so both state blocks see one decision
  arb_lock_state i_lock_state (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .flush_i   ( flush_i ),
    .req_i     ( req_i   ),
    .out_req_i ( req_o   ),
    .gnt_i     ( gnt_i   ),
    .eff_req_o ( eff_req )
  );

  rr_priority_state i_priority_state (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .flush_i   ( flush_i ),
    .eff_req_i ( eff_req ),
    .out_req_i ( req_o   ),
    .gnt_i     ( gnt_i   ),
    .rr_o      ( rr      )
  );

  //////////////////////////////////////////////////////////////////////
  // redundant arbitration and vote
  //////////////////////////////////////////////////////////////////////

  for (genvar j = 0; j < `ARB_NUM_COPIES; j++) begin : gen_tree
    rr_arb_tree i_tree (
      .eff_req_i ( eff_req      ),
      .rr_i      ( rr           ),
      .data_i    ( data_i       ),
      .gnt_i     ( gnt_i        ),
      .gnt_o     ( tree_gnt[j]  ),
      .req_o     ( tree_req[j]  ),
      .idx_o     ( tree_idx[j]  ),
      .data_o    ( tree_data[j] )
    );
  end

  tmr_decision_voter i_voter (
    .gnt_i   ( tree_gnt  ),
    .req_i   ( tree_req  ),
    .idx_i   ( tree_idx  ),
    .data_i  ( tree_data ),
    .gnt_o   ( gnt_o     ),
    .req_o   ( req_o     ),
    .idx_o   ( idx_o     ),
    .data_o  ( data_o    ),
    .fault_o ( fault_o   )
  );

endmodule

/* source/tmr_decision_voter.sv */
// majority voter over the three arbitration tree copies
// bitwise vote of grant, request, index and payload, plus a fault
// flag raised whenever any copy disagrees with the voted result

`timescale 1ns/1ns
`include "rel_arb_config.svh"

module tmr_decision_voter (
  input  rel_arb_pkg::arb_req_vec_t [`ARB_NUM_COPIES-1:0] gnt_i,
  input  logic [`ARB_NUM_COPIES-1:0]                      req_i,
  input  rel_arb_pkg::arb_idx_t [`ARB_NUM_COPIES-1:0]     idx_i,
  input  rel_arb_pkg::arb_data_t [`ARB_NUM_COPIES-1:0]    data_i,
  output rel_arb_pkg::arb_req_vec_t                       gnt_o,
  output logic                                            req_o,
  output rel_arb_pkg::arb_idx_t                           idx_o,
  output rel_arb_pkg::arb_data_t                          data_o,
  output logic                                            fault_o
);

  // each field is voted bit by bit, one faulty copy is outvoted
  assign gnt_o  = (gnt_i[0] & gnt_i[1]) | (gnt_i[0] & gnt_i[2]) | (gnt_i[1] & gnt_i[2]);
  assign req_o  = (req_i[0] & req_i[1]) | (req_i[0] & req_i[2]) | (req_i[1] & req_i[2]);
  assign idx_o  = (idx_i[0] & idx_i[1]) | (idx_i[0] & idx_i[2]) | (idx_i[1] & idx_i[2]);
  assign data_o = (data_i[0] & data_i[1]) | (data_i[0] & data_i[2]) |
                  (data_i[1] & data_i[2]);

  // any copy off the vote in any field is reported
  always_comb begin : p_fault
    fault_o = 1'b0;
    for (int j = 0; j < `ARB_NUM_COPIES; j++) begin
      fault_o |= (gnt_i[j] != gnt_o) | (req_i[j] != req_o) |
                 (idx_i[j] != idx_o) | (data_i[j] != data_o);
    end
  end

  // checked once the trees have settled
  always_comb begin : p_check
    assert final ($onehot0(gnt_o))
      else $error("voted grant is not one-hot or zero");
    // a grant leaving the arbiter needs a pending output request
    assert final (!(|gnt_o) || req_o)
      else $error("grant out without an output request");
    // the granted requester is the one whose index and payload go out
    assert final (!(|gnt_o) || gnt_o[idx_o])
      else $error("grant vector does not match the output index");
  end

endmodule

/* source/rr_arb_tree.sv */
// one copy of the logarithmic round-robin arbitration tree
// request reduction and index selection from the leaves to the root,
// payload multiplexing, and the grant path back to the chosen leaf

`timescale 1ns/1ns
`include "rel_arb_config.svh"

module rr_arb_tree (
  input  rel_arb_pkg::arb_req_vec_t                  eff_req_i,
  input  rel_arb_pkg::arb_idx_t                      rr_i,
  input  rel_arb_pkg::arb_data_t [`ARB_NUM_IN-1:0]   data_i,
  input  logic                                       gnt_i,
  output rel_arb_pkg::arb_req_vec_t                  gnt_o,
  output logic                                       req_o,
  output rel_arb_pkg::arb_idx_t                      idx_o,
  output rel_arb_pkg::arb_data_t                     data_o
);

  // level 0 is the root, level NumLevels holds the leaves
  localparam int NumLevels = `ARB_IDX_WIDTH;
  localparam int NumPairs  = `ARB_NUM_IN / 2;

  logic [NumLevels:0][`ARB_NUM_IN-1:0]                   req_nodes;
  rel_arb_pkg::arb_idx_t [NumLevels:0][`ARB_NUM_IN-1:0]  idx_nodes;
  rel_arb_pkg::arb_data_t [NumLevels:0][`ARB_NUM_IN-1:0] data_nodes;
  logic [NumLevels:0][`ARB_NUM_IN-1:0]                   gnt_nodes;
  logic [NumLevels-1:0][NumPairs-1:0]                    sel_nodes;

  //////////////////////////////////////////////////////////////////////
  // upward pass, leaves to root
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_reduce
    req_nodes  = '0;
    idx_nodes  = '0;
    data_nodes = '0;
    sel_nodes  = '0;
    req_nodes[NumLevels]  = eff_req_i;
    data_nodes[NumLevels] = data_i;
    for (int lvl = NumLevels - 1; lvl >= 0; lvl--) begin
      for (int n = 0; n < NumPairs; n++) begin
        // level lvl only has 2**lvl live nodes
        if (n < (1 << lvl)) begin
          // take the upper child if the lower is idle
          // or if it requests and the priority bit of this level points up
          sel_nodes[lvl][n] = ~req_nodes[lvl+1][2*n] |
                              (req_nodes[lvl+1][2*n+1] & rr_i[NumLevels-1-lvl]);
          req_nodes[lvl][n] = req_nodes[lvl+1][2*n] | req_nodes[lvl+1][2*n+1];
          if (sel_nodes[lvl][n]) begin
            idx_nodes[lvl][n]  = idx_nodes[lvl+1][2*n+1];
            data_nodes[lvl][n] = data_nodes[lvl+1][2*n+1];
          end else begin
            idx_nodes[lvl][n]  = idx_nodes[lvl+1][2*n];
            data_nodes[lvl][n] = data_nodes[lvl+1][2*n];
          end
          // the root decides the MSB, the last level decides bit 0
          idx_nodes[lvl][n][NumLevels-1-lvl] = sel_nodes[lvl][n];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // downward pass, grant to the chosen leaf
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_grant
    gnt_nodes       = '0;
    gnt_nodes[0][0] = gnt_i;
    for (int lvl = 0; lvl < NumLevels; lvl++) begin
      for (int n = 0; n < NumPairs; n++) begin
        if (n < (1 << lvl)) begin
          gnt_nodes[lvl+1][2*n]   = gnt_nodes[lvl][n] & ~sel_nodes[lvl][n];
          gnt_nodes[lvl+1][2*n+1] = gnt_nodes[lvl][n] & sel_nodes[lvl][n];
        end
      end
    end
  end

  // a leaf is only granted when it actually requests
  assign gnt_o  = gnt_nodes[NumLevels] & eff_req_i;
  assign req_o  = req_nodes[0][0];
  assign idx_o  = idx_nodes[0][0];
  assign data_o = data_nodes[0][0];

endmodule

/* source/rr_priority_state.sv */
// fair round-robin priority state
// three copies of the masked trailing-zero searches that pick the
// next priority, their majority vote and the priority register

`timescale 1ns/1ns
`include "rel_arb_config.svh"

module rr_priority_state (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  rel_arb_pkg::arb_req_vec_t eff_req_i,
  input  logic                      out_req_i,
  input  logic                      gnt_i,
  output rel_arb_pkg::arb_idx_t     rr_o
);

  rel_arb_pkg::arb_idx_t rr_q;
  rel_arb_pkg::arb_idx_t rr_d;
  rel_arb_pkg::arb_idx_t [`ARB_NUM_COPIES-1:0] rr_copy;

  // index of the lowest set bit, zero for an empty vector
  function automatic rel_arb_pkg::arb_idx_t lowest_set(input rel_arb_pkg::arb_req_vec_t vec);
    rel_arb_pkg::arb_idx_t idx;
    idx = '0;
    // scanning downward lets the lowest set bit overwrite the others
    for (int i = `ARB_NUM_IN - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = rel_arb_pkg::arb_idx_t'(i);
      end
    end
    return idx;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // redundant next-priority searches
  //////////////////////////////////////////////////////////////////////

  for (genvar j = 0; j < `ARB_NUM_COPIES; j++) begin : gen_copy
    rel_arb_pkg::arb_req_vec_t upper_mask;
    rel_arb_pkg::arb_req_vec_t lower_mask;
    rel_arb_pkg::arb_idx_t     next_idx;

    // split the requests at the current priority
    // upper holds strictly higher indices, lower the rest
    always_comb begin : p_mask
      for (int i = 0; i < `ARB_NUM_IN; i++) begin
        upper_mask[i] = eff_req_i[i] & (i > int'(rr_q));
        lower_mask[i] = eff_req_i[i] & (i <= int'(rr_q));
      end
    end

    // wrap around to the lower half only when nothing above is waiting
    assign next_idx   = (|upper_mask) ? lowest_set(upper_mask) : lowest_set(lower_mask);
    // the priority only advances when a transfer completes
    assign rr_copy[j] = (out_req_i && gnt_i) ? next_idx : rr_q;
  end

  // bitwise majority before the register
  assign rr_d = (rr_copy[0] & rr_copy[1]) |
                (rr_copy[0] & rr_copy[2]) |
                (rr_copy[1] & rr_copy[2]);

  //////////////////////////////////////////////////////////////////////
  // priority register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr_reg
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (flush_i) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

  assign rr_o = rr_q;

  // a completed transfer hands the priority to a requester that is waiting
  a_rr_next_requests : assert property (
    @(posedge clk_i) disable iff (!rst_ni || flush_i)
    (out_req_i && gnt_i) |-> eff_req_i[rr_d]
  ) else $error("next priority points at an idle requester");

endmodule

/* source/arb_lock_state.sv */
// lock-in of the arbitration decision under back-pressure
// three copies of the next lock bit and held requests, their vote,
// the lock and request registers, and the effective request mux

`timescale 1ns/1ns
`include "rel_arb_config.svh"

module arb_lock_state (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  rel_arb_pkg::arb_req_vec_t req_i,
  input  logic                      out_req_i,
  input  logic                      gnt_i,
  output rel_arb_pkg::arb_req_vec_t eff_req_o
);

  rel_arb_pkg::lock_state_e lock_q;
  rel_arb_pkg::lock_state_e lock_d;
  rel_arb_pkg::arb_req_vec_t req_q;
  rel_arb_pkg::arb_req_vec_t req_d;
  logic [`ARB_NUM_COPIES-1:0] lock_copy;
  rel_arb_pkg::arb_req_vec_t [`ARB_NUM_COPIES-1:0] req_copy;

  //////////////////////////////////////////////////////////////////////
  // redundant next-state logic
  //////////////////////////////////////////////////////////////////////

  // each copy decides on its own whether the decision must be frozen
  // a pending request without a grant locks, a transfer releases
  for (genvar j = 0; j < `ARB_NUM_COPIES; j++) begin : gen_copy
    assign lock_copy[j] = out_req_i & ~gnt_i;
    // while held the stored vector recirculates, otherwise sample the inputs
    assign req_copy[j]  = (lock_q == rel_arb_pkg::LOCK_HELD) ? req_q : req_i;
  end

  // majority of the three copies, taken before the registers
  assign lock_d = ((lock_copy[0] & lock_copy[1]) |
                   (lock_copy[0] & lock_copy[2]) |
                   (lock_copy[1] & lock_copy[2])) ? rel_arb_pkg::LOCK_HELD
                                                  : rel_arb_pkg::LOCK_OPEN;

  assign req_d = (req_copy[0] & req_copy[1]) |
                 (req_copy[0] & req_copy[2]) |
                 (req_copy[1] & req_copy[2]);

  //////////////////////////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lock_regs
    if (!rst_ni) begin
      lock_q <= rel_arb_pkg::LOCK_OPEN;
      req_q  <= '0;
    end else if (flush_i) begin
      // flush drops the held decision along with its requests
      lock_q <= rel_arb_pkg::LOCK_OPEN;
      req_q  <= '0;
    end else begin
      lock_q <= lock_d;
      req_q  <= req_d;
    end
  end

  // the trees only ever see the frozen vector while the lock holds
  assign eff_req_o = (lock_q == rel_arb_pkg::LOCK_HELD) ? req_q : req_i;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // a held decision still has its request pending at the output
  a_locked_req_pending : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (lock_q == rel_arb_pkg::LOCK_HELD) |-> out_req_i
  ) else $error("output request dropped while the decision was locked");

  // requesters must keep every held request up until their grant
  a_held_req_kept : assert property (
    @(posedge clk_i) disable iff (!rst_ni || flush_i)
    (out_req_i && !gnt_i) |=> ((req_i & eff_req_o) == eff_req_o)
  ) else $error("a held request dropped before it was granted");

endmodule

/* source/rel_arb_pkg.sv */
// shared types of the triple-redundant round-robin arbiter
// index and priority values, payloads, request and grant vectors,
// and the lock state of the held arbitration decision

`include "rel_arb_config.svh"

package rel_arb_pkg;

  //////////////////////////////////////////////////////////////////////
  // data types
  //////////////////////////////////////////////////////////////////////

  // a requester index, also used as the round-robin priority
  typedef logic [`ARB_IDX_WIDTH-1:0] arb_idx_t;

  // payload offered by one requester
  typedef logic [`ARB_DATA_WIDTH-1:0] arb_data_t;

  // one bit per requester, used for requests as well as grants
  typedef logic [`ARB_NUM_IN-1:0] arb_req_vec_t;

  //////////////////////////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////////////////////////

  // LOCK_HELD freezes the requests the tree sees until the transfer
  typedef enum logic {
    LOCK_OPEN = 1'b0,
    LOCK_HELD = 1'b1
  } lock_state_e;

endpackage

/* source/rel_arb_config.svh */
// sizing macros for the triple-redundant round-robin arbiter
// requester count, payload width, index width and the number of
// redundant copies of the arbitration logic

`ifndef REL_ARB_CONFIG_SVH
`define REL_ARB_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// arbiter sizing
//////////////////////////////////////////////////////////////////////

// number of requesters competing for the output
`define ARB_NUM_IN 8

// payload carried by every requester, in bits
`define ARB_DATA_WIDTH 16

// width of a requester index, log2 of the requester count
`define ARB_IDX_WIDTH 3

// copies of the decision logic, combined by majority vote
`define ARB_NUM_COPIES 3

`endif
